//--- design/glb_settings.svh
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// channel and bank organisation
`define GLB_NUM_CHANNELS 4
`define GLB_NUM_BANKS 8
`define GLB_BANKS_PER_CHANNEL 2
`define GLB_CHANNEL_SEL_WIDTH 2

// word and address widths
`define GLB_DATA_WIDTH 16
`define GLB_BANK_ADDR_WIDTH 8
`define GLB_BANK_SEL_WIDTH 3
`define GLB_ADDR_WIDTH 11
`define GLB_COUNT_WIDTH 16

// config bus and register field widths
`define GLB_CFG_ADDR_WIDTH 8
`define GLB_CFG_DATA_WIDTH 32
`define GLB_CFG_FEATURE_WIDTH 4
`define GLB_CFG_REG_WIDTH 4
`define GLB_MODE_WIDTH 2
`define GLB_SWITCH_WIDTH 3

`endif

//--- design/glb_pkg.sv
`default_nettype none

`include "glb_settings.svh"

package glb_pkg;

    // operating mode of one io controller
    typedef enum logic [`GLB_MODE_WIDTH-1:0] {
        MODE_IDLE      = 2'd0,
        MODE_INSTREAM  = 2'd1,
        MODE_OUTSTREAM = 2'd2,
        MODE_DIRECT    = 2'd3
    } io_mode_t;

    // one-word bank access, controller side or bank side
    typedef struct packed {
        logic                         wr_en;
        logic                         rd_en;
        logic [`GLB_ADDR_WIDTH-1:0]   addr;
        logic [`GLB_DATA_WIDTH-1:0]   wr_data;
    } bank_req_t;

    // config access from outside
    typedef struct packed {
        logic                           en;
        logic                           wr;
        logic                           rd;
        logic [`GLB_CFG_ADDR_WIDTH-1:0] addr;
        logic [`GLB_CFG_DATA_WIDTH-1:0] wr_data;
    } cfg_bus_t;

    // per-channel controller settings
    typedef struct packed {
        io_mode_t                     mode;
        logic [`GLB_ADDR_WIDTH-1:0]   start_addr;
        logic [`GLB_COUNT_WIDTH-1:0]  num_words;
    } io_ctrl_cfg_t;

endpackage

`default_nettype wire

//--- design/glb_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "glb_settings.svh"

module glb_config_regs (
    input  wire                              clk,
    input  wire                              reset,
    input  wire glb_pkg::cfg_bus_t           cfg,
    output logic [`GLB_CFG_DATA_WIDTH-1:0]   cfg_rd_data,
    output glb_pkg::io_ctrl_cfg_t            channel_cfg [`GLB_NUM_CHANNELS],
    output logic [`GLB_SWITCH_WIDTH-1:0]     switch_sel
);

    logic [`GLB_CFG_FEATURE_WIDTH-1:0] feature;
    logic [`GLB_CFG_REG_WIDTH-1:0]     reg_field;
    logic                              wr_strobe;
    logic                              rd_strobe;

    // feature field picks a channel or the interconnect
    assign feature   = cfg.addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_CFG_FEATURE_WIDTH];
    assign reg_field = cfg.addr[`GLB_CFG_REG_WIDTH-1:0];
    assign wr_strobe = cfg.en && cfg.wr;
    assign rd_strobe = cfg.en && cfg.rd;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            switch_sel <= '0;
            for (int i = 0; i < `GLB_NUM_CHANNELS; i++) begin
                channel_cfg[i].mode       <= glb_pkg::MODE_IDLE;
                channel_cfg[i].start_addr <= '0;
                channel_cfg[i].num_words  <= '0;
            end
        end else if (wr_strobe) begin
            if (feature == `GLB_CFG_FEATURE_WIDTH'(`GLB_NUM_CHANNELS) && reg_field == 0) begin
                switch_sel <= cfg.wr_data[`GLB_SWITCH_WIDTH-1:0];
            end
            for (int i = 0; i < `GLB_NUM_CHANNELS; i++) begin
                if (feature == `GLB_CFG_FEATURE_WIDTH'(i)) begin
                    case (reg_field)
                        0: channel_cfg[i].mode <=
                            glb_pkg::io_mode_t'(cfg.wr_data[`GLB_MODE_WIDTH-1:0]);
                        1: channel_cfg[i].start_addr <= cfg.wr_data[`GLB_ADDR_WIDTH-1:0];
                        2: channel_cfg[i].num_words <= cfg.wr_data[`GLB_COUNT_WIDTH-1:0];
                        default: ;
                    endcase
                end
            end
        end
    end

    // read-back, zero for anything unmapped
    always_comb begin
        cfg_rd_data = '0;
        if (rd_strobe) begin
            if (feature == `GLB_CFG_FEATURE_WIDTH'(`GLB_NUM_CHANNELS)) begin
                if (reg_field == 0) begin
                    cfg_rd_data = `GLB_CFG_DATA_WIDTH'(switch_sel);
                end
            end
            for (int i = 0; i < `GLB_NUM_CHANNELS; i++) begin
                if (feature == `GLB_CFG_FEATURE_WIDTH'(i)) begin
                    case (reg_field)
                        0: cfg_rd_data = `GLB_CFG_DATA_WIDTH'(channel_cfg[i].mode);
                        1: cfg_rd_data = `GLB_CFG_DATA_WIDTH'(channel_cfg[i].start_addr);
                        2: cfg_rd_data = `GLB_CFG_DATA_WIDTH'(channel_cfg[i].num_words);
                        default: cfg_rd_data = '0;
                    endcase
                end
            end
        end
    end

    // a config access is either a read or a write
    a_cfg_strobes: assert property (
        @(posedge clk) disable iff (reset)
        cfg.en |-> !(cfg.wr && cfg.rd)
    );

endmodule

`default_nettype wire

//--- design/io_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "glb_settings.svh"

module io_controller (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            stall,
    input  wire                            start_pulse,
    input  wire glb_pkg::io_ctrl_cfg_t     channel_cfg,
    input  wire                            wr_en,
    input  wire                            rd_en,
    input  wire [`GLB_DATA_WIDTH-1:0]      wr_data,
    input  wire [`GLB_DATA_WIDTH-1:0]      addr_high,
    input  wire [`GLB_DATA_WIDTH-1:0]      addr_low,
    output logic [`GLB_DATA_WIDTH-1:0]     rd_data,
    output logic                           rd_data_valid,
    output glb_pkg::bank_req_t             bank_req,
    input  wire [`GLB_DATA_WIDTH-1:0]      bank_rd_data
);

    logic                          direct;
    logic                          active;
    logic                          wr_acc;
    logic                          rd_acc;
    logic [`GLB_ADDR_WIDTH-1:0]    offset;
    logic [`GLB_COUNT_WIDTH-1:0]   remaining;
    logic [`GLB_ADDR_WIDTH-1:0]    next_addr;
    logic                          cmd_wr;
    logic                          cmd_rd;
    logic [`GLB_ADDR_WIDTH-1:0]    cmd_addr;
    logic [`GLB_DATA_WIDTH-1:0]    cmd_data;
    logic                          req_wr;
    logic                          req_rd;
    logic [`GLB_ADDR_WIDTH-1:0]    req_addr;
    logic [`GLB_DATA_WIDTH-1:0]    req_data;
    logic [2:0]                    rd_valid_pipe;

    assign direct = (channel_cfg.mode == glb_pkg::MODE_DIRECT);

    // direct mode ignores the word count
    assign active = !stall && (channel_cfg.mode != glb_pkg::MODE_IDLE)
                    && (direct || remaining != '0);
    assign wr_acc = active && wr_en
                    && (direct || channel_cfg.mode == glb_pkg::MODE_OUTSTREAM);
    assign rd_acc = active && rd_en
                    && (direct || channel_cfg.mode == glb_pkg::MODE_INSTREAM);

    // bank field from the high half, word address from the low half
    assign next_addr = direct ?
        {addr_high[`GLB_BANK_SEL_WIDTH-1:0], addr_low[`GLB_BANK_ADDR_WIDTH-1:0]} :
        channel_cfg.start_addr + offset;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            offset    <= '0;
            remaining <= '0;
        end else if (start_pulse) begin
            offset    <= '0;
            remaining <= channel_cfg.num_words;
        end else if (!direct && (wr_acc || rd_acc)) begin
            offset    <= offset + 1'b1;
            remaining <= remaining - 1'b1;
        end
    end

    // first stage holds the accepted command
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_wr <= 1'b0;
            cmd_rd <= 1'b0;
            req_wr <= 1'b0;
            req_rd <= 1'b0;
            rd_valid_pipe <= '0;
        end else begin
            cmd_wr <= wr_acc;
            cmd_rd <= rd_acc;
            req_wr <= cmd_wr;
            req_rd <= cmd_rd;
            // data returns three edges after the command stage
            rd_valid_pipe <= {rd_valid_pipe[1:0], cmd_rd};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc || rd_acc) begin
            cmd_addr <= next_addr;
            cmd_data <= wr_data;
        end
        req_addr <= cmd_addr;
        req_data <= cmd_data;
    end

    assign bank_req = '{wr_en: req_wr, rd_en: req_rd, addr: req_addr, wr_data: req_data};

    assign rd_data       = bank_rd_data;
    assign rd_data_valid = rd_valid_pipe[2];

    a_no_dual_accept: assert property (
        @(posedge clk) disable iff (reset)
        !(wr_acc && rd_acc)
    );

endmodule

`default_nettype wire

//--- design/io_bank_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

`include "glb_settings.svh"

module io_bank_interconnect (
    input  wire                           clk,
    input  wire                           reset,
    input  wire [`GLB_SWITCH_WIDTH-1:0]   switch_sel,
    input  wire glb_pkg::bank_req_t       channel_req [`GLB_NUM_CHANNELS],
    output logic [`GLB_DATA_WIDTH-1:0]    channel_rd_data [`GLB_NUM_CHANNELS],
    output glb_pkg::bank_req_t            bank_req [`GLB_NUM_BANKS],
    input  wire [`GLB_DATA_WIDTH-1:0]     bank_rd_data [`GLB_NUM_BANKS]
);

    glb_pkg::bank_req_t                  eff_req [`GLB_NUM_CHANNELS];
    logic [`GLB_CHANNEL_SEL_WIDTH-1:0]   eff_src [`GLB_NUM_CHANNELS];
    logic                                bank_hit [`GLB_NUM_BANKS];
    logic                                bank_rd_d1 [`GLB_NUM_BANKS];
    logic                                bank_rd_d2 [`GLB_NUM_BANKS];
    logic [`GLB_DATA_WIDTH-1:0]          bank_data_d1 [`GLB_NUM_BANKS];
    logic [`GLB_DATA_WIDTH-1:0]          rd_chain [`GLB_NUM_BANKS];
    logic [`GLB_NUM_BANKS-1:0]           src_hits [`GLB_NUM_CHANNELS];

    // clear switch bit hands the channel below's request upward
    always_comb begin
        eff_req[0] = channel_req[0];
        eff_src[0] = '0;
        for (int j = 1; j < `GLB_NUM_CHANNELS; j++) begin
            if (switch_sel[j-1]) begin
                eff_req[j] = channel_req[j];
                eff_src[j] = `GLB_CHANNEL_SEL_WIDTH'(j);
            end else begin
                eff_req[j] = eff_req[j-1];
                eff_src[j] = eff_src[j-1];
            end
        end
    end

    // only the bank named by the bank field sees the enables
    always_comb begin
        for (int k = 0; k < `GLB_NUM_BANKS; k++) begin
            bank_hit[k] = eff_req[k / `GLB_BANKS_PER_CHANNEL].addr[`GLB_ADDR_WIDTH-1 -:
                `GLB_BANK_SEL_WIDTH] == `GLB_BANK_SEL_WIDTH'(k);
            bank_req[k].wr_en   = eff_req[k / `GLB_BANKS_PER_CHANNEL].wr_en && bank_hit[k];
            bank_req[k].rd_en   = eff_req[k / `GLB_BANKS_PER_CHANNEL].rd_en && bank_hit[k];
            bank_req[k].addr    = {{`GLB_BANK_SEL_WIDTH{1'b0}},
                eff_req[k / `GLB_BANKS_PER_CHANNEL].addr[`GLB_BANK_ADDR_WIDTH-1:0]};
            bank_req[k].wr_data = eff_req[k / `GLB_BANKS_PER_CHANNEL].wr_data;
        end
    end

    // read enable delayed to line up with the registered bank data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `GLB_NUM_BANKS; k++) begin
                bank_rd_d1[k] <= 1'b0;
                bank_rd_d2[k] <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `GLB_NUM_BANKS; k++) begin
                bank_rd_d1[k] <= bank_req[k].rd_en;
                bank_rd_d2[k] <= bank_rd_d1[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `GLB_NUM_BANKS; k++) begin
            bank_data_d1[k] <= bank_rd_data[k];
        end
    end

    // return chain runs from the top bank down
    always_comb begin
        rd_chain[`GLB_NUM_BANKS-1] = bank_rd_d2[`GLB_NUM_BANKS-1] ?
            bank_data_d1[`GLB_NUM_BANKS-1] : '0;
        for (int k = `GLB_NUM_BANKS - 2; k >= 0; k--) begin
            rd_chain[k] = bank_rd_d2[k] ? bank_data_d1[k] : rd_chain[k+1];
        end
        for (int j = 0; j < `GLB_NUM_CHANNELS; j++) begin
            channel_rd_data[j] = rd_chain[j * `GLB_BANKS_PER_CHANNEL];
        end
    end

    // banks enabled on behalf of each originating channel
    always_comb begin
        for (int s = 0; s < `GLB_NUM_CHANNELS; s++) begin
            for (int k = 0; k < `GLB_NUM_BANKS; k++) begin
                src_hits[s][k] = (eff_src[k / `GLB_BANKS_PER_CHANNEL] ==
                    `GLB_CHANNEL_SEL_WIDTH'(s)) && (bank_req[k].wr_en || bank_req[k].rd_en);
            end
        end
    end

    for (genvar s = 0; s < `GLB_NUM_CHANNELS; s++) begin : g_src_check
        a_one_bank_per_source: assert property (
            @(posedge clk) disable iff (reset)
            $onehot0(src_hits[s])
        );
    end

endmodule

`default_nettype wire

//--- design/glb_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "glb_settings.svh"

module glb_bank (
    input  wire                          clk,
    input  wire                          reset,
    input  wire glb_pkg::bank_req_t      req,
    output logic [`GLB_DATA_WIDTH-1:0]   rd_data
);

    localparam int DEPTH = 1 << `GLB_BANK_ADDR_WIDTH;

    logic [`GLB_DATA_WIDTH-1:0]      mem [DEPTH];
    logic [`GLB_BANK_ADDR_WIDTH-1:0] word_addr;

    // bank field already stripped by the interconnect
    assign word_addr = req.addr[`GLB_BANK_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            mem[word_addr] <= req.wr_data;
        end
    end

    // output holds until the next read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (req.rd_en) begin
            rd_data <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

//--- design/glb_io_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "glb_settings.svh"

module glb_io_top (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            stall,
    input  wire                            start_pulse,
    input  wire glb_pkg::cfg_bus_t         cfg,
    output logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_rd_data,
    input  wire                            wr_en [`GLB_NUM_CHANNELS],
    input  wire                            rd_en [`GLB_NUM_CHANNELS],
    input  wire [`GLB_DATA_WIDTH-1:0]      wr_data [`GLB_NUM_CHANNELS],
    input  wire [`GLB_DATA_WIDTH-1:0]      addr_high [`GLB_NUM_CHANNELS],
    input  wire [`GLB_DATA_WIDTH-1:0]      addr_low [`GLB_NUM_CHANNELS],
    output logic [`GLB_DATA_WIDTH-1:0]     rd_data [`GLB_NUM_CHANNELS],
    output logic                           rd_data_valid [`GLB_NUM_CHANNELS]
);

    glb_pkg::io_ctrl_cfg_t          channel_cfg [`GLB_NUM_CHANNELS];
    logic [`GLB_SWITCH_WIDTH-1:0]   switch_sel;
    glb_pkg::bank_req_t             ctrl_req [`GLB_NUM_CHANNELS];
    logic [`GLB_DATA_WIDTH-1:0]     ctrl_rd_data [`GLB_NUM_CHANNELS];
    glb_pkg::bank_req_t             bank_req [`GLB_NUM_BANKS];
    logic [`GLB_DATA_WIDTH-1:0]     bank_rd_data [`GLB_NUM_BANKS];

    glb_config_regs u_config_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .cfg_rd_data (cfg_rd_data),
        .channel_cfg (channel_cfg),
        .switch_sel  (switch_sel)
    );

    for (genvar i = 0; i < `GLB_NUM_CHANNELS; i++) begin : g_ctrl
        io_controller u_io_controller (
            .clk           (clk),
            .reset         (reset),
            .stall         (stall),
            .start_pulse   (start_pulse),
            .channel_cfg   (channel_cfg[i]),
            .wr_en         (wr_en[i]),
            .rd_en         (rd_en[i]),
            .wr_data       (wr_data[i]),
            .addr_high     (addr_high[i]),
            .addr_low      (addr_low[i]),
            .rd_data       (rd_data[i]),
            .rd_data_valid (rd_data_valid[i]),
            .bank_req      (ctrl_req[i]),
            .bank_rd_data  (ctrl_rd_data[i])
        );
    end

    io_bank_interconnect u_interconnect (
        .clk             (clk),
        .reset           (reset),
        .switch_sel      (switch_sel),
        .channel_req     (ctrl_req),
        .channel_rd_data (ctrl_rd_data),
        .bank_req        (bank_req),
        .bank_rd_data    (bank_rd_data)
    );

    for (genvar k = 0; k < `GLB_NUM_BANKS; k++) begin : g_bank
        glb_bank u_bank (
            .clk     (clk),
            .reset   (reset),
            .req     (bank_req[k]),
            .rd_data (bank_rd_data[k])
        );
    end

endmodule

`default_nettype wire

//--- verification/glb_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "glb_settings.svh"

module glb_io_tb;

    localparam int DRAIN_LIMIT = 50;
    localparam int NUM_DIRECT = 16;

    logic                            clk;
    logic                            reset;
    logic                            stall;
    logic                            start_pulse;
    glb_pkg::cfg_bus_t               cfg;
    logic [`GLB_CFG_DATA_WIDTH-1:0]  cfg_rd_data;
    logic                            wr_en [`GLB_NUM_CHANNELS];
    logic                            rd_en [`GLB_NUM_CHANNELS];
    logic [`GLB_DATA_WIDTH-1:0]      wr_data [`GLB_NUM_CHANNELS];
    logic [`GLB_DATA_WIDTH-1:0]      addr_high [`GLB_NUM_CHANNELS];
    logic [`GLB_DATA_WIDTH-1:0]      addr_low [`GLB_NUM_CHANNELS];
    logic [`GLB_DATA_WIDTH-1:0]      rd_data [`GLB_NUM_CHANNELS];
    logic                            rd_data_valid [`GLB_NUM_CHANNELS];

    // reference memory and the controller state it implies
    logic [`GLB_DATA_WIDTH-1:0]      ref_mem [1 << `GLB_ADDR_WIDTH];
    glb_pkg::io_mode_t               model_mode [`GLB_NUM_CHANNELS];
    logic [`GLB_ADDR_WIDTH-1:0]      model_start [`GLB_NUM_CHANNELS];
    logic [`GLB_ADDR_WIDTH-1:0]      model_offset [`GLB_NUM_CHANNELS];
    logic [`GLB_COUNT_WIDTH-1:0]     model_count [`GLB_NUM_CHANNELS];
    logic [`GLB_COUNT_WIDTH-1:0]     model_left [`GLB_NUM_CHANNELS];
    logic [`GLB_SWITCH_WIDTH-1:0]    model_switch;
    logic                            hold_stall;
    logic                            follow_chk;

    // expected returns shifted to line up with the read latency
    logic                            exp_acc [`GLB_NUM_CHANNELS];
    logic                            exp_known [`GLB_NUM_CHANNELS];
    logic [`GLB_DATA_WIDTH-1:0]      exp_word [`GLB_NUM_CHANNELS];
    logic [3:0]                      acc_pipe [`GLB_NUM_CHANNELS];
    logic [3:0]                      known_pipe [`GLB_NUM_CHANNELS];
    logic [3:0][`GLB_DATA_WIDTH-1:0] word_pipe [`GLB_NUM_CHANNELS];

    string                           test_name;
    int                              check_errors;
    int                              timeout_errors;

    glb_io_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk or posedge reset) begin
        for (int c = 0; c < `GLB_NUM_CHANNELS; c++) begin
            if (reset) begin
                acc_pipe[c]   <= '0;
                known_pipe[c] <= '0;
                word_pipe[c]  <= '0;
            end else begin
                acc_pipe[c]   <= {acc_pipe[c][2:0], exp_acc[c]};
                known_pipe[c] <= {known_pipe[c][2:0], exp_acc[c] && exp_known[c]};
                word_pipe[c]  <= {word_pipe[c][2:0], exp_word[c]};
            end
        end
    end

    for (genvar c = 0; c < `GLB_NUM_CHANNELS; c++) begin : g_check
        a_valid_match: assert property (@(posedge clk) disable iff (reset)
            rd_data_valid[c] == acc_pipe[c][3])
        else begin
            check_errors++;
            $display("error %s: channel %0d valid expected %0b actual %0b", test_name, c,
                $sampled(acc_pipe[c][3]), $sampled(rd_data_valid[c]));
        end
        a_data_match: assert property (@(posedge clk) disable iff (reset)
            known_pipe[c][3] |-> rd_data[c] == word_pipe[c][3])
        else begin
            check_errors++;
            $display("error %s: channel %0d data expected %h actual %h", test_name, c,
                $sampled(word_pipe[c][3]), $sampled(rd_data[c]));
        end
    end

    // bypassed channel 1 returns the word expected on channel 0
    a_follow_ch0: assert property (@(posedge clk) disable iff (reset)
        (follow_chk && known_pipe[0][3]) |-> rd_data[1] == word_pipe[0][3])
    else begin
        check_errors++;
        $display("error %s: channel 1 data expected %h actual %h", test_name,
            $sampled(word_pipe[0][3]), $sampled(rd_data[1]));
    end

    function automatic logic [`GLB_CFG_DATA_WIDTH-1:0] field_mask(int width);
        return (`GLB_CFG_DATA_WIDTH'(1) << width) - 1'b1;
    endfunction

    // channel whose request reaches a bank group through the switches
    function automatic int source_of(int group);
        int src;
        src = 0;
        for (int g = 1; g <= group; g++) begin
            if (model_switch[g-1]) begin
                src = g;
            end
        end
        return src;
    endfunction

    function automatic logic reads_pending();
        logic pending;
        pending = 1'b0;
        for (int c = 0; c < `GLB_NUM_CHANNELS; c++) begin
            pending = pending || exp_acc[c] || (acc_pipe[c] != '0) || rd_data_valid[c];
        end
        return pending;
    endfunction

    task automatic clear_all();
        cfg = '0;
        start_pulse = 1'b0;
        stall = hold_stall;
        for (int c = 0; c < `GLB_NUM_CHANNELS; c++) begin
            wr_en[c] = 1'b0;
            rd_en[c] = 1'b0;
            wr_data[c] = '0;
            addr_high[c] = '0;
            addr_low[c] = '0;
            exp_acc[c] = 1'b0;
            exp_known[c] = 1'b0;
        end
    endtask

    task automatic apply_reset();
        hold_stall = 1'b0;
        follow_chk = 1'b0;
        reset = 1'b1;
        clear_all();
        model_switch = '0;
        for (int c = 0; c < `GLB_NUM_CHANNELS; c++) begin
            model_mode[c] = glb_pkg::MODE_IDLE;
            model_start[c] = '0;
            model_offset[c] = '0;
            model_count[c] = '0;
            model_left[c] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic finish_run();
        $display("checks failed: %0d, timeouts: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (reads_pending() && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            clear_all();
            cycles++;
        end
        if (reads_pending()) begin
            timeout_errors++;
            $display("timeout in %s: reads still outstanding after %0d cycles",
                test_name, DRAIN_LIMIT);
        end
    endtask

    task automatic cfg_write(int feature, int field, logic [`GLB_CFG_DATA_WIDTH-1:0] data);
        @(negedge clk);
        clear_all();
        cfg = '{en: 1'b1, wr: 1'b1, rd: 1'b0,
            addr: `GLB_CFG_ADDR_WIDTH'((feature << `GLB_CFG_REG_WIDTH) | field),
            wr_data: data};
        @(negedge clk);
        clear_all();
    endtask

    task automatic cfg_check(int feature, int field, logic [`GLB_CFG_DATA_WIDTH-1:0] expected);
        @(negedge clk);
        clear_all();
        cfg = '{en: 1'b1, wr: 1'b0, rd: 1'b1,
            addr: `GLB_CFG_ADDR_WIDTH'((feature << `GLB_CFG_REG_WIDTH) | field),
            wr_data: '0};
        @(posedge clk);
        assert (cfg_rd_data == expected)
        else begin
            check_errors++;
            $display("error %s: config %h expected %h actual %h", test_name, cfg.addr,
                expected, cfg_rd_data);
        end
    endtask

    task automatic setup_channel(int ch, glb_pkg::io_mode_t mode,
                                 logic [`GLB_ADDR_WIDTH-1:0] start,
                                 logic [`GLB_COUNT_WIDTH-1:0] count);
        cfg_write(ch, 0, `GLB_CFG_DATA_WIDTH'(mode));
        cfg_write(ch, 1, `GLB_CFG_DATA_WIDTH'(start));
        cfg_write(ch, 2, `GLB_CFG_DATA_WIDTH'(count));
        model_mode[ch] = mode;
        model_start[ch] = start;
        model_count[ch] = count;
    endtask

    task automatic set_switch(logic [`GLB_SWITCH_WIDTH-1:0] value);
        cfg_write(`GLB_NUM_CHANNELS, 0, `GLB_CFG_DATA_WIDTH'(value));
        model_switch = value;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        clear_all();
        start_pulse = 1'b1;
        for (int c = 0; c < `GLB_NUM_CHANNELS; c++) begin
            model_offset[c] = '0;
            model_left[c] = model_count[c];
        end
        @(negedge clk);
        clear_all();
    endtask

    // one array-side operation and its predicted effect
    task automatic issue(int ch, logic wr, logic rd, logic [`GLB_DATA_WIDTH-1:0] data,
                         logic [`GLB_DATA_WIDTH-1:0] high, logic [`GLB_DATA_WIDTH-1:0] low);
        logic                       direct;
        logic                       active;
        logic                       wr_ok;
        logic                       rd_ok;
        logic                       reach;
        logic [`GLB_ADDR_WIDTH-1:0] addr;
        @(negedge clk);
        clear_all();
        wr_en[ch] = wr;
        rd_en[ch] = rd;
        wr_data[ch] = data;
        addr_high[ch] = high;
        addr_low[ch] = low;
        direct = (model_mode[ch] == glb_pkg::MODE_DIRECT);
        active = !hold_stall && model_mode[ch] != glb_pkg::MODE_IDLE
                 && (direct || model_left[ch] != '0);
        wr_ok = active && wr && (direct || model_mode[ch] == glb_pkg::MODE_OUTSTREAM);
        rd_ok = active && rd && (direct || model_mode[ch] == glb_pkg::MODE_INSTREAM);
        addr = direct ? {high[`GLB_BANK_SEL_WIDTH-1:0], low[`GLB_BANK_ADDR_WIDTH-1:0]} :
            model_start[ch] + model_offset[ch];
        reach = source_of(int'(addr[`GLB_ADDR_WIDTH-1 -: `GLB_BANK_SEL_WIDTH])
                / `GLB_BANKS_PER_CHANNEL) == ch;
        if (wr_ok && reach) begin
            ref_mem[addr] = data;
        end
        exp_acc[ch] = rd_ok;
        exp_known[ch] = reach;
        exp_word[ch] = ref_mem[addr];
        if (!direct && (wr_ok || rd_ok)) begin
            model_offset[ch] = model_offset[ch] + 1'b1;
            model_left[ch] = model_left[ch] - 1'b1;
        end
    endtask

    task automatic check_reset_state();
        for (int f = 0; f <= `GLB_NUM_CHANNELS; f++) begin
            for (int r = 0; r < 3; r++) begin
                cfg_check(f, r, '0);
            end
        end
        repeat (4) begin
            @(negedge clk);
            for (int c = 0; c < `GLB_NUM_CHANNELS; c++) begin
                assert (rd_data_valid[c] == 1'b0)
                else begin
                    check_errors++;
                    $display("error %s: channel %0d valid expected 0 actual %0b",
                        test_name, c, rd_data_valid[c]);
                end
            end
        end
    endtask

    initial begin
        logic [`GLB_DATA_WIDTH-1:0]     dir_high [NUM_DIRECT];
        logic [`GLB_DATA_WIDTH-1:0]     dir_low [NUM_DIRECT];
        logic [`GLB_CFG_DATA_WIDTH-1:0] mode_v;
        logic [`GLB_CFG_DATA_WIDTH-1:0] start_v;
        logic [`GLB_CFG_DATA_WIDTH-1:0] count_v;
        check_errors = 0;
        timeout_errors = 0;
        void'($urandom(32'h9380));
        apply_reset();

        test_name = "reset_state";
        check_reset_state();

        test_name = "config_readback";
        for (int f = 0; f < `GLB_NUM_CHANNELS; f++) begin
            mode_v = $urandom;
            start_v = $urandom;
            count_v = $urandom;
            cfg_write(f, 0, mode_v);
            cfg_write(f, 1, start_v);
            cfg_write(f, 2, count_v);
            cfg_check(f, 0, mode_v & field_mask(`GLB_MODE_WIDTH));
            cfg_check(f, 1, start_v & field_mask(`GLB_ADDR_WIDTH));
            cfg_check(f, 2, count_v & field_mask(`GLB_COUNT_WIDTH));
        end
        mode_v = $urandom;
        cfg_write(`GLB_NUM_CHANNELS, 0, mode_v);
        cfg_check(`GLB_NUM_CHANNELS, 0, mode_v & field_mask(`GLB_SWITCH_WIDTH));
        cfg_check(0, 3, '0);
        cfg_check(`GLB_NUM_CHANNELS, 1, '0);
        cfg_check(7, 0, '0);
        cfg_check(15, 15, '0);

        // span crosses from bank 0 into bank 1
        // three extra enables each way
        test_name = "stream_ch0";
        set_switch(3'b111);
        setup_channel(0, glb_pkg::MODE_OUTSTREAM, 11'h0f0, 16'd32);
        pulse_start();
        for (int i = 0; i < 35; i++) begin
            issue(0, 1'b1, 1'b0, 16'($urandom), '0, '0);
        end
        setup_channel(0, glb_pkg::MODE_INSTREAM, 11'h0f0, 16'd32);
        pulse_start();
        for (int i = 0; i < 35; i++) begin
            issue(0, 1'b0, 1'b1, '0, '0, '0);
        end
        wait_drain();

        test_name = "switch_clear";
        set_switch(3'b110);
        setup_channel(0, glb_pkg::MODE_OUTSTREAM, 11'h200, 16'd8);
        setup_channel(1, glb_pkg::MODE_OUTSTREAM, 11'h200, 16'd8);
        pulse_start();
        for (int i = 0; i < 8; i++) begin
            issue(0, 1'b1, 1'b0, 16'($urandom), '0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            issue(1, 1'b1, 1'b0, 16'($urandom), '0, '0);
        end
        setup_channel(0, glb_pkg::MODE_INSTREAM, 11'h200, 16'd8);
        pulse_start();
        follow_chk = 1'b1;
        for (int i = 0; i < 8; i++) begin
            issue(0, 1'b0, 1'b1, '0, '0, '0);
        end
        wait_drain();
        follow_chk = 1'b0;

        test_name = "switch_set";
        set_switch(3'b111);
        setup_channel(1, glb_pkg::MODE_OUTSTREAM, 11'h2f8, 16'd16);
        pulse_start();
        for (int i = 0; i < 16; i++) begin
            issue(1, 1'b1, 1'b0, 16'($urandom), '0, '0);
        end
        setup_channel(1, glb_pkg::MODE_INSTREAM, 11'h2f8, 16'd16);
        pulse_start();
        for (int i = 0; i < 16; i++) begin
            issue(1, 1'b0, 1'b1, '0, '0, '0);
        end
        wait_drain();

        // stalled writes must leave the earlier stream data in place
        test_name = "stall";
        setup_channel(0, glb_pkg::MODE_OUTSTREAM, 11'h0f0, 16'd4);
        pulse_start();
        hold_stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue(0, 1'b1, 1'b0, 16'($urandom), '0, '0);
        end
        hold_stall = 1'b0;
        setup_channel(0, glb_pkg::MODE_INSTREAM, 11'h0f0, 16'd8);
        pulse_start();
        for (int i = 0; i < 12; i++) begin
            hold_stall = (i >= 3 && i < 6);
            issue(0, 1'b0, 1'b1, '0, '0, '0);
        end
        hold_stall = 1'b0;
        wait_drain();

        // direct mode has no word limit
        test_name = "direct_ch2";
        setup_channel(2, glb_pkg::MODE_DIRECT, '0, '0);
        for (int i = 0; i < NUM_DIRECT; i++) begin
            dir_high[i] = 16'($urandom);
            dir_high[i][`GLB_BANK_SEL_WIDTH-1:0] = {2'b10, dir_high[i][0]};
            dir_low[i] = 16'($urandom);
            issue(2, 1'b1, 1'b0, 16'($urandom), dir_high[i], dir_low[i]);
        end
        for (int i = 0; i < NUM_DIRECT; i++) begin
            issue(2, 1'b0, 1'b1, '0, dir_high[i], dir_low[i]);
        end
        wait_drain();

        test_name = "reset_again";
        apply_reset();
        check_reset_state();

        finish_run();
    end

endmodule

`default_nettype wire

//--- glb_io.f
+incdir+design
design/glb_pkg.sv
design/glb_config_regs.sv
design/io_controller.sv
design/io_bank_interconnect.sv
design/glb_bank.sv
design/glb_io_top.sv
verification/glb_io_tb.sv
